// ==== logic/spi_bridge_pkg.sv ====
package spi_bridge_pkg;

    // Byte width on SPI and data width on APB
    localparam int DATA_W = 8;

    // Single-byte address on APB
    localparam int ADDR_W = 8;

    // Words in the target memory
    localparam int MEM_DEPTH = 256;

    // Opcodes accepted in the first byte of a transaction
    typedef enum logic [7:0] {
        CMD_WRITE = 8'h02,
        CMD_READ  = 8'h03
    } cmd_op_e;

    // Position inside the SPI transaction
    typedef enum logic [1:0] {
        ST_CMD,
        ST_ADDR,
        ST_DATA,
        ST_IGNORE
    } xfer_state_e;

    // APB master phases
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

    // Shifted out on MISO whenever no read data is due
    localparam logic [DATA_W-1:0] FILL_BYTE = 8'h00;

endpackage

// ==== logic/spi_byte.sv ====
module spi_byte (
    input  logic                              clk_sys_i,
    // Chip select high also clears the byte state
    input  logic                              spi_cs_ni,
    // Must be low when chip select falls
    input  logic                              spi_sclk_i,
    input  logic                              spi_rx_i,
    input  logic [spi_bridge_pkg::DATA_W-1:0] tx_byte_i,
    output logic                              spi_tx_o,
    output logic [spi_bridge_pkg::DATA_W-1:0] rx_byte_o,
    output logic                              rx_valid_o,
    output logic                              cs_active_o
);
    import spi_bridge_pkg::*;

    // Two-stage synchronizers on the SPI pins
    // Chip select starts out inactive so the engine idles before the first edge
    logic cs_n_q1 = 1'b1;
    logic cs_n_q2 = 1'b1;
    logic sclk_q1;
    logic sclk_q2;
    logic rx_q1;
    logic rx_q2;

    // Extra SCLK stage for edge detection
    logic sclk_q3;
    logic sclk_rise;
    logic sclk_fall;

    // MOSI enters at the bottom, MISO leaves from the top
    logic [DATA_W-1:0] sr_q;
    logic [DATA_W-1:0] sr_d;

    // Bits seen so far in the current byte
    logic [$clog2(DATA_W)-1:0] bit_cnt_q;
    logic [$clog2(DATA_W)-1:0] bit_cnt_d;

    logic [DATA_W-1:0] rx_byte_d;
    logic              rx_valid_d;
    logic              spi_tx_d;

    assign sclk_rise   = sclk_q2 && !sclk_q3;
    assign sclk_fall   = !sclk_q2 && sclk_q3;
    assign cs_active_o = !cs_n_q2;

    always_comb begin
        sr_d       = sr_q;
        bit_cnt_d  = bit_cnt_q;
        rx_byte_d  = rx_byte_o;
        rx_valid_d = 1'b0;
        spi_tx_d   = spi_tx_o;

        if (cs_n_q2) begin
            // Idle: keep the next tx byte preloaded for the falling chip select
            bit_cnt_d = '0;
            sr_d      = tx_byte_i;
            spi_tx_d  = tx_byte_i[DATA_W-1];
        end else if (sclk_rise) begin
            // Sample MOSI, which also moves the next tx bit to the top
            sr_d      = {sr_q[DATA_W-2:0], rx_q2};
            bit_cnt_d = bit_cnt_q + 1'b1;
            if (bit_cnt_q == '1) begin
                // Eighth bit in
                rx_byte_d  = {sr_q[DATA_W-2:0], rx_q2};
                rx_valid_d = 1'b1;
            end
        end else if (sclk_fall) begin
            if (bit_cnt_q == '0) begin
                // Byte boundary, take the next tx byte from the decoder
                sr_d     = tx_byte_i;
                spi_tx_d = tx_byte_i[DATA_W-1];
            end else begin
                // Present the next bit ahead of the rising edge
                spi_tx_d = sr_q[DATA_W-1];
            end
        end
    end

    always_ff @(posedge clk_sys_i) begin
        cs_n_q1 <= spi_cs_ni;
        cs_n_q2 <= cs_n_q1;
        sclk_q1 <= spi_sclk_i;
        sclk_q2 <= sclk_q1;
        sclk_q3 <= sclk_q2;
        rx_q1   <= spi_rx_i;
        rx_q2   <= rx_q1;
    end

    always_ff @(posedge clk_sys_i) begin
        sr_q       <= sr_d;
        bit_cnt_q  <= bit_cnt_d;
        rx_byte_o  <= rx_byte_d;
        rx_valid_o <= rx_valid_d;
        spi_tx_o   <= spi_tx_d;
    end

endmodule

// ==== logic/spi_cmd_decoder.sv ====
module spi_cmd_decoder (
    input  logic                              clk_sys_i,
    input  logic                              rst_i,
    input  logic                              cs_active_i,
    input  logic [spi_bridge_pkg::DATA_W-1:0] rx_byte_i,
    input  logic                              rx_valid_i,
    input  logic                              done_i,
    input  logic [spi_bridge_pkg::DATA_W-1:0] rdata_i,
    output logic [spi_bridge_pkg::DATA_W-1:0] tx_byte_o,
    output logic                              req_o,
    output logic                              we_o,
    output logic [spi_bridge_pkg::ADDR_W-1:0] addr_o,
    output logic [spi_bridge_pkg::DATA_W-1:0] wdata_o
);
    import spi_bridge_pkg::*;

    xfer_state_e state_q;
    cmd_op_e     op_q;

    // Address for the next data byte
    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] cur_addr;

    logic is_read;
    logic issue;

    assign is_read = (op_q == CMD_READ);

    // During the address byte the address comes straight off the wire
    assign cur_addr = (state_q == ST_ADDR) ? ADDR_W'(rx_byte_i) : addr_q;

    // Reads prefetch on the address byte and on every data byte
    // Writes go out on data bytes only
    assign issue = rx_valid_i && cs_active_i &&
                   ((state_q == ST_ADDR && is_read) || state_q == ST_DATA);

    always_ff @(posedge clk_sys_i) begin
        if (rst_i || !cs_active_i) begin
            state_q <= ST_CMD;
        end else if (rx_valid_i) begin
            case (state_q)
                ST_CMD: begin
                    case (rx_byte_i)
                        CMD_WRITE, CMD_READ: state_q <= ST_ADDR;
                        // Unknown opcode, drop everything until chip select rises
                        default: state_q <= ST_IGNORE;
                    endcase
                end
                ST_ADDR: state_q <= ST_DATA;
                // ST_DATA and ST_IGNORE hold until chip select rises
                default: state_q <= state_q;
            endcase
        end
    end

    // Opcode is only looked at once the state has left ST_CMD
    always_ff @(posedge clk_sys_i) begin
        if (rx_valid_i && state_q == ST_CMD) begin
            op_q <= cmd_op_e'(rx_byte_i);
        end
    end

    always_ff @(posedge clk_sys_i) begin
        // Pointer moves on by one after each request
        if (rx_valid_i && (state_q == ST_ADDR || state_q == ST_DATA)) begin
            addr_q <= cur_addr + ADDR_W'(issue);
        end
        // Request payload, held until the next request
        if (issue) begin
            addr_o  <= cur_addr;
            we_o    <= !is_read;
            wdata_o <= rx_byte_i;
        end
    end

    // Single-cycle strobe one cycle after the byte arrives
    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            req_o <= 1'b0;
        end else begin
            req_o <= issue;
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (rst_i || !cs_active_i) begin
            tx_byte_o <= FILL_BYTE;
        end else if (done_i && !we_o) begin
            // Prefetched byte, picked up by the engine at the next byte boundary
            tx_byte_o <= rdata_i;
        end
    end

endmodule

// ==== logic/apb_master.sv ====
module apb_master (
    input  logic                              clk_sys_i,
    input  logic                              rst_i,
    input  logic                              req_i,
    input  logic                              we_i,
    input  logic [spi_bridge_pkg::ADDR_W-1:0] addr_i,
    input  logic [spi_bridge_pkg::DATA_W-1:0] wdata_i,
    input  logic [spi_bridge_pkg::DATA_W-1:0] prdata_i,
    input  logic                              pready_i,
    output logic                              done_o,
    output logic [spi_bridge_pkg::DATA_W-1:0] rdata_o,
    output logic                              psel_o,
    output logic                              penable_o,
    output logic                              pwrite_o,
    output logic [spi_bridge_pkg::ADDR_W-1:0] paddr_o,
    output logic [spi_bridge_pkg::DATA_W-1:0] pwdata_o
);
    import spi_bridge_pkg::*;

    apb_state_e state_q;

    // Bus strobes follow the phase directly
    assign psel_o    = (state_q != APB_IDLE);
    assign penable_o = (state_q == APB_ACCESS);

    // Completion in the access cycle that sees pready
    assign done_o  = penable_o && pready_i;
    assign rdata_o = prdata_i;

    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            state_q <= APB_IDLE;
        end else begin
            case (state_q)
                APB_IDLE:   if (req_i) state_q <= APB_SETUP;
                APB_SETUP:  state_q <= APB_ACCESS;
                // Stay in access through wait states
                APB_ACCESS: if (pready_i) state_q <= APB_IDLE;
                default:    state_q <= APB_IDLE;
            endcase
        end
    end

    // Address and control captured once, stable for the whole transfer
    always_ff @(posedge clk_sys_i) begin
        if (state_q == APB_IDLE && req_i) begin
            pwrite_o <= we_i;
            paddr_o  <= addr_i;
            pwdata_o <= wdata_i;
        end
    end

endmodule

// ==== logic/apb_sram.sv ====
module apb_sram (
    input  logic                              clk_sys_i,
    input  logic                              rst_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [spi_bridge_pkg::ADDR_W-1:0] paddr_i,
    input  logic [spi_bridge_pkg::DATA_W-1:0] pwdata_i,
    output logic [spi_bridge_pkg::DATA_W-1:0] prdata_o,
    output logic                              pready_o
);
    import spi_bridge_pkg::*;

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic              access;

    assign access = psel_i && penable_i;

    // One wait state: low in the first access cycle, high in the second
    always_ff @(posedge clk_sys_i) begin
        if (rst_i) begin
            pready_o <= 1'b0;
        end else begin
            pready_o <= access && !pready_o;
        end
    end

    always_ff @(posedge clk_sys_i) begin
        // Read data loaded during the wait so it is valid with pready
        if (access && !pready_o) begin
            prdata_o <= mem[paddr_i];
        end
        // Write commits at the end of the ready cycle
        if (access && pready_o && pwrite_i) begin
            mem[paddr_i] <= pwdata_i;
        end
    end

endmodule

// ==== logic/spi_apb_bridge_top.sv ====
module spi_apb_bridge_top (
    input  logic clk_sys_i,
    input  logic rst_i,
    input  logic spi_cs_ni,
    input  logic spi_sclk_i,
    input  logic spi_mosi_i,
    output logic spi_miso_o
);
    import spi_bridge_pkg::*;

    // Byte engine to decoder
    logic [DATA_W-1:0] rx_byte;
    logic              rx_valid;
    logic              cs_active;
    logic [DATA_W-1:0] tx_byte;

    // Decoder to APB master
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              done;
    logic [DATA_W-1:0] rdata;

    // APB
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;

    spi_byte i_spi_byte (
        .clk_sys_i  (clk_sys_i),
        .spi_cs_ni  (spi_cs_ni),
        .spi_sclk_i (spi_sclk_i),
        .spi_rx_i   (spi_mosi_i),
        .tx_byte_i  (tx_byte),
        .spi_tx_o   (spi_miso_o),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid),
        .cs_active_o(cs_active)
    );

    spi_cmd_decoder i_decoder (
        .clk_sys_i  (clk_sys_i),
        .rst_i      (rst_i),
        .cs_active_i(cs_active),
        .rx_byte_i  (rx_byte),
        .rx_valid_i (rx_valid),
        .done_i     (done),
        .rdata_i    (rdata),
        .tx_byte_o  (tx_byte),
        .req_o      (req),
        .we_o       (we),
        .addr_o     (addr),
        .wdata_o    (wdata)
    );

    apb_master i_apb_master (
        .clk_sys_i(clk_sys_i),
        .rst_i    (rst_i),
        .req_i    (req),
        .we_i     (we),
        .addr_i   (addr),
        .wdata_i  (wdata),
        .prdata_i (prdata),
        .pready_i (pready),
        .done_o   (done),
        .rdata_o  (rdata),
        .psel_o   (psel),
        .penable_o(penable),
        .pwrite_o (pwrite),
        .paddr_o  (paddr),
        .pwdata_o (pwdata)
    );

    apb_sram i_apb_sram (
        .clk_sys_i(clk_sys_i),
        .rst_i    (rst_i),
        .psel_i   (psel),
        .penable_i(penable),
        .pwrite_i (pwrite),
        .paddr_i  (paddr),
        .pwdata_i (pwdata),
        .prdata_o (prdata),
        .pready_o (pready)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // Period of 100 time units
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = !clk_o;
    end

    // Reset held over the first 3 rising edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== tb/spi_bridge_props.sv ====
module spi_bridge_props (
    input logic clk_sys_i,
    input logic rst_i,
    input logic spi_cs_ni,
    input logic spi_sclk_i,
    input logic spi_mosi_i,
    input logic spi_miso_i
);
    import spi_bridge_pkg::*;

    // Failed assertions, read by the testbench top at the end
    int unsigned err_cnt = 0;

    // Pin level byte reconstruction
    logic              sclk_q;
    logic [2:0]        bit_cnt;
    logic [DATA_W-1:0] mosi_sr;
    logic [DATA_W-1:0] miso_sr;
    logic [DATA_W-1:0] mosi_byte;
    logic [DATA_W-1:0] miso_byte;
    logic              byte_done;

    // Transaction model: 0 opcode, 1 address, 2 data
    logic [1:0]        byte_idx;
    cmd_op_e           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] shadow [MEM_DEPTH];
    logic [DATA_W-1:0] exp_byte;

    assign exp_byte = shadow[addr_q];

    always_ff @(posedge clk_sys_i) begin
        sclk_q    <= spi_sclk_i;
        byte_done <= 1'b0;
        if (spi_cs_ni) begin
            // A partial byte is simply dropped here
            bit_cnt <= '0;
        end else if (spi_sclk_i && !sclk_q) begin
            mosi_sr <= {mosi_sr[DATA_W-2:0], spi_mosi_i};
            miso_sr <= {miso_sr[DATA_W-2:0], spi_miso_i};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
                mosi_byte <= {mosi_sr[DATA_W-2:0], spi_mosi_i};
                miso_byte <= {miso_sr[DATA_W-2:0], spi_miso_i};
                byte_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (spi_cs_ni) begin
            byte_idx <= 2'd0;
        end else if (byte_done) begin
            // Index saturates once the data phase is reached
            if (byte_idx != 2'd2) begin
                byte_idx <= byte_idx + 1'b1;
            end
            if (byte_idx == 2'd0) begin
                op_q <= cmd_op_e'(mosi_byte);
            end else if (byte_idx == 2'd1) begin
                addr_q <= mosi_byte;
            end else if (op_q == CMD_WRITE || op_q == CMD_READ) begin
                if (op_q == CMD_WRITE) begin
                    shadow[addr_q] <= mosi_byte;
                end
                // Wraps past the top of memory
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    // MISO idles low once reset is released
    a_reset_miso: assert property (@(posedge clk_sys_i)
        $fell(rst_i) |-> !spi_miso_i)
        else begin
            err_cnt++;
            $error("FAILED %0t spi_miso_o: got %b, expected 0", $time, $sampled(spi_miso_i));
        end

    // Opcode, address, write and ignored bytes shift out the fill byte
    a_fill_byte: assert property (@(posedge clk_sys_i) disable iff (rst_i)
        byte_done && (byte_idx != 2'd2 || op_q != CMD_READ) |-> miso_byte == FILL_BYTE)
        else begin
            err_cnt++;
            $error("FAILED %0t spi_miso_o: got %h, expected %h",
                   $time, $sampled(miso_byte), FILL_BYTE);
        end

    // Read data bytes follow the shadow memory
    a_read_data: assert property (@(posedge clk_sys_i) disable iff (rst_i)
        byte_done && byte_idx == 2'd2 && op_q == CMD_READ |-> miso_byte === exp_byte)
        else begin
            err_cnt++;
            $error("FAILED %0t spi_miso_o: got %h, expected %h",
                   $time, $sampled(miso_byte), $sampled(exp_byte));
        end

    // MISO only moves while SCLK is low
    a_miso_stable: assert property (@(posedge clk_sys_i) disable iff (rst_i || spi_cs_ni)
        spi_sclk_i && $past(spi_sclk_i) |-> $stable(spi_miso_i))
        else begin
            err_cnt++;
            $error("MISO changed at %0t while SCLK was high", $time);
        end

endmodule

// ==== tb/tb_spi_bridge.sv ====
module tb_spi_bridge;
    import spi_bridge_pkg::*;

    // SCLK half period in system clock cycles
    localparam int HALF_CYC = 8;
    localparam int RST_WAIT = 20;

    logic clk_sys;
    logic rst;
    logic spi_cs_n = 1'b1;
    logic spi_sclk = 1'b0;
    logic spi_mosi = 1'b0;
    logic spi_miso;

    int unsigned timeouts = 0;
    logic [31:0] lcg_state = 32'h805f;
    // Data bytes for the next transaction
    logic [7:0]  data_buf [8];

    tb_clk_gen i_clk_gen (
        .clk_o(clk_sys),
        .rst_o(rst)
    );

    spi_apb_bridge_top i_dut (
        .clk_sys_i (clk_sys),
        .rst_i     (rst),
        .spi_cs_ni (spi_cs_n),
        .spi_sclk_i(spi_sclk),
        .spi_mosi_i(spi_mosi),
        .spi_miso_o(spi_miso)
    );

    bind spi_apb_bridge_top spi_bridge_props i_props (
        .clk_sys_i (clk_sys_i),
        .rst_i     (rst_i),
        .spi_cs_ni (spi_cs_ni),
        .spi_sclk_i(spi_sclk_i),
        .spi_mosi_i(spi_mosi_i),
        .spi_miso_i(spi_miso_o)
    );

    function automatic logic [7:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    task automatic fill_random(input int nbytes);
        for (int k = 0; k < nbytes; k++) begin
            data_buf[k] = next_random();
        end
    endtask

    // Mode 0, MSB first, all pin changes on rising clk_sys edges
    task automatic shift_byte(input logic [7:0] value, input int nbits);
        int n;
        for (int i = 0; i < nbits; i++) begin
            spi_mosi <= value[7-i];
            repeat (HALF_CYC) @(posedge clk_sys);
            spi_sclk <= 1'b1;
            n = 0;
            if (i == 7) begin
                // Byte strobe is due a few cycles after the eighth rising edge
                do begin
                    @(posedge clk_sys);
                    n++;
                end while (!i_dut.rx_valid && n < HALF_CYC);
                if (!i_dut.rx_valid) begin
                    timeouts++;
                    $display("Timeout at %0t: byte %h was never received", $time, value);
                end
            end
            repeat (HALF_CYC - n) @(posedge clk_sys);
            spi_sclk <= 1'b0;
        end
    endtask

    task automatic start_frame();
        @(posedge clk_sys);
        spi_cs_n <= 1'b0;
        repeat (HALF_CYC) @(posedge clk_sys);
    endtask

    task automatic end_frame();
        int n;
        repeat (HALF_CYC) @(posedge clk_sys);
        spi_cs_n <= 1'b1;
        n = 0;
        do begin
            @(posedge clk_sys);
            n++;
        end while (i_dut.cs_active && n < RST_WAIT);
        if (i_dut.cs_active) begin
            timeouts++;
            $display("Timeout at %0t: chip select release not seen by the bridge", $time);
        end
        repeat (HALF_CYC) @(posedge clk_sys);
    endtask

    // Opcode, address, then nbytes from data_buf
    task automatic run_xfer(input logic [7:0] op, input logic [7:0] addr, input int nbytes);
        start_frame();
        shift_byte(op, 8);
        shift_byte(addr, 8);
        for (int k = 0; k < nbytes; k++) begin
            shift_byte(data_buf[k], 8);
        end
        end_frame();
    endtask

    initial begin
        int n;
        n = 0;
        do begin
            @(posedge clk_sys);
            n++;
        end while (rst !== 1'b0 && n < RST_WAIT);
        if (rst !== 1'b0) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end

        // Write then read back
        fill_random(4);
        run_xfer(CMD_WRITE, 8'h10, 4);
        run_xfer(CMD_READ, 8'h10, 4);

        // Burst across the top of the address space
        fill_random(6);
        run_xfer(CMD_WRITE, 8'hFD, 6);
        run_xfer(CMD_READ, 8'hFD, 6);

        // Unknown opcode must leave memory alone
        fill_random(4);
        run_xfer(8'h5A, 8'h10, 4);
        run_xfer(CMD_READ, 8'h10, 4);

        // One full data byte, then a byte cut after 5 bits
        fill_random(2);
        start_frame();
        shift_byte(CMD_WRITE, 8);
        shift_byte(8'h11, 8);
        shift_byte(data_buf[0], 8);
        shift_byte(data_buf[1], 5);
        end_frame();
        run_xfer(CMD_READ, 8'h11, 2);

        $display("Errors: assertions %0d, timeouts %0d", i_dut.i_props.err_cnt, timeouts);
        if (i_dut.i_props.err_cnt == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== spi_apb_bridge.f ====
logic/spi_bridge_pkg.sv
logic/spi_byte.sv
logic/spi_cmd_decoder.sv
logic/apb_master.sv
logic/apb_sram.sv
logic/spi_apb_bridge_top.sv
tb/tb_clk_gen.sv
tb/spi_bridge_props.sv
tb/tb_spi_bridge.sv

// ==== Bender.yml ====
package:
  name: spi_apb_bridge

sources:
  # Package first, then the blocks, then the top level
  - logic/spi_bridge_pkg.sv
  - logic/spi_byte.sv
  - logic/spi_cmd_decoder.sv
  - logic/apb_master.sv
  - logic/apb_sram.sv
  - logic/spi_apb_bridge_top.sv

  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/spi_bridge_props.sv
      - tb/tb_spi_bridge.sv
